// File: common/adder_axil_pkg.sv
package adder_axil_pkg;

    // AXI-Lite response codes carried on bresp and rresp
    // EXOKAY and DECERR are never produced by this slave
    typedef enum logic [1:0]
    {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

endpackage

// File: common/adder_regmap_pkg.sv
package adder_regmap_pkg;

    // Byte offsets within the peripheral window
    typedef logic [3:0] reg_offset_t;

    // Operands, host writable
    localparam reg_offset_t OFFSET_OPERAND_A = 4'h0;
    localparam reg_offset_t OFFSET_OPERAND_B = 4'h4;

    // Sum and flags, read only
    localparam reg_offset_t OFFSET_RESULT    = 4'h8;
    localparam reg_offset_t OFFSET_STATUS    = 4'hc;

    // Status register layout
    localparam int STATUS_WIDTH        = 2;
    localparam int STATUS_CARRY_BIT    = 0;
    localparam int STATUS_OVERFLOW_BIT = 1;

    // Carry and signed overflow of the last committed addition
    typedef logic [STATUS_WIDTH-1:0] status_t;

endpackage

// File: axil/axil_write_ctrl.sv
module axil_write_ctrl #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 8
)
(
    input  logic                           s1_axi_aclk,
    input  logic                           arst_n,

    // AW channel
    input  logic [ADDR_WIDTH-1:0]          awaddr,
    input  logic                           awvalid,
    output logic                           awready,

    // W channel
    input  logic [DATA_WIDTH-1:0]          wdata,
    input  logic [DATA_WIDTH/8-1:0]        wstrb,
    input  logic                           wvalid,
    output logic                           wready,

    // B channel
    output adder_axil_pkg::axil_resp_t     bresp,
    output logic                           bvalid,
    input  logic                           bready,

    // Commit request towards the register bank
    output logic                           wr_en,
    output logic [ADDR_WIDTH-1:0]          wr_addr,
    output logic [DATA_WIDTH-1:0]          wr_data,
    output logic [DATA_WIDTH/8-1:0]        wr_strb,
    input  adder_axil_pkg::axil_resp_t     wr_resp
);

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [DATA_WIDTH/8-1:0] strb_t;

    // One-entry buffers for address and data
    addr_t aw_addr_q;
    data_t w_data_q;
    strb_t w_strb_q;
    logic  aw_full;
    logic  w_full;
    logic  commit;

    assign awready = !aw_full;
    assign wready  = !w_full;

    // Both halves present and the B slot free
    assign commit = aw_full && w_full && !bvalid;

    assign wr_en   = commit;
    assign wr_addr = aw_addr_q;
    assign wr_data = w_data_q;
    assign wr_strb = w_strb_q;

    always_ff @(posedge s1_axi_aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= adder_axil_pkg::RESP_OKAY;
        end
        else
        begin
            // Buffers drain on commit, fill on handshake
            if (commit)
            begin
                aw_full <= 1'b0;
            end
            else if (awvalid && awready)
            begin
                aw_full <= 1'b1;
            end

            if (commit)
            begin
                w_full <= 1'b0;
            end
            else if (wvalid && wready)
            begin
                w_full <= 1'b1;
            end

            // Bank decides the response in the commit cycle
            if (commit)
            begin
                bvalid <= 1'b1;
                bresp  <= wr_resp;
            end
            else if (bvalid && bready)
            begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge s1_axi_aclk)
    begin
        if (awvalid && awready)
        begin
            aw_addr_q <= awaddr;
        end
        if (wvalid && wready)
        begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
    end

    // Response held until the master takes it
    a_b_hold: assert property (
        @(posedge s1_axi_aclk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

    // A commit is a single pulse that leaves the bank's decode waiting on B
    a_commit_to_b: assert property (
        @(posedge s1_axi_aclk) disable iff (!arst_n)
        wr_en |=> bvalid && !wr_en && (bresp == $past(wr_resp))
    );

endmodule

// File: axil/axil_read_ctrl.sv
module axil_read_ctrl #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 8
)
(
    input  logic                        s1_axi_aclk,
    input  logic                        arst_n,

    // AR channel
    input  logic [ADDR_WIDTH-1:0]       araddr,
    input  logic                        arvalid,
    output logic                        arready,

    // R channel
    output logic [DATA_WIDTH-1:0]       rdata,
    output adder_axil_pkg::axil_resp_t  rresp,
    output logic                        rvalid,
    input  logic                        rready,

    // Combinational lookup in the register bank
    output logic [ADDR_WIDTH-1:0]       rd_addr,
    input  logic [DATA_WIDTH-1:0]       rd_data,
    input  adder_axil_pkg::axil_resp_t  rd_resp
);

    typedef enum logic
    {
        IDLE,
        RESP
    } state_t;

    state_t state;
    logic   ar_hs;

    assign arready = (state == IDLE);
    assign rvalid  = (state == RESP);
    assign ar_hs   = arvalid && arready;

    // Bank is sampled on the AR handshake edge itself
    assign rd_addr = araddr;

    always_ff @(posedge s1_axi_aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= IDLE;
            rresp <= adder_axil_pkg::RESP_OKAY;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (ar_hs)
                    begin
                        state <= RESP;
                        rresp <= rd_resp;
                    end
                end
                RESP:
                begin
                    if (rready)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge s1_axi_aclk)
    begin
        if (ar_hs)
        begin
            rdata <= rd_data;
        end
    end

    // Data and response frozen while the master stalls
    a_r_hold: assert property (
        @(posedge s1_axi_aclk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

// File: rtl/adder_regs.sv
module adder_regs #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 8
)
(
    input  logic                        s1_axi_aclk,
    input  logic                        arst_n,

    // Write commit from the write controller
    input  logic                        wr_en,
    input  logic [ADDR_WIDTH-1:0]       wr_addr,
    input  logic [DATA_WIDTH-1:0]       wr_data,
    input  logic [DATA_WIDTH/8-1:0]     wr_strb,
    output adder_axil_pkg::axil_resp_t  wr_resp,

    // Read lookup from the read controller
    input  logic [ADDR_WIDTH-1:0]       rd_addr,
    output logic [DATA_WIDTH-1:0]       rd_data,
    output adder_axil_pkg::axil_resp_t  rd_resp
);

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [DATA_WIDTH/8-1:0] strb_t;
    typedef logic [DATA_WIDTH:0]     sum_t;

    localparam addr_t ADDR_OPERAND_A = addr_t'(adder_regmap_pkg::OFFSET_OPERAND_A);
    localparam addr_t ADDR_OPERAND_B = addr_t'(adder_regmap_pkg::OFFSET_OPERAND_B);
    localparam addr_t ADDR_RESULT    = addr_t'(adder_regmap_pkg::OFFSET_RESULT);
    localparam addr_t ADDR_STATUS    = addr_t'(adder_regmap_pkg::OFFSET_STATUS);

    data_t                     operand_a;
    data_t                     operand_b;
    data_t                     result;
    adder_regmap_pkg::status_t status;

    logic                      wr_sel_a;
    logic                      wr_sel_b;
    data_t                     next_a;
    data_t                     next_b;
    sum_t                      next_sum;
    adder_regmap_pkg::status_t next_status;

    // Keep old bytes where the strobe is low
    function automatic data_t merge_bytes(input data_t old_val, input data_t new_val,
                                          input strb_t strb);
        data_t merged;
        merged = old_val;
        for (int i = 0; i < DATA_WIDTH/8; i++)
        begin
            if (strb[i])
            begin
                merged[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return merged;
    endfunction

    // Full address compare, so unaligned offsets miss every register
    assign wr_sel_a = (wr_addr == ADDR_OPERAND_A);
    assign wr_sel_b = (wr_addr == ADDR_OPERAND_B);
    assign wr_resp  = (wr_sel_a || wr_sel_b) ? adder_axil_pkg::RESP_OKAY
                                             : adder_axil_pkg::RESP_SLVERR;

    // Operand pair as it will look after this commit
    assign next_a   = wr_sel_a ? merge_bytes(operand_a, wr_data, wr_strb) : operand_a;
    assign next_b   = wr_sel_b ? merge_bytes(operand_b, wr_data, wr_strb) : operand_b;
    assign next_sum = {1'b0, next_a} + {1'b0, next_b};

    always_comb
    begin
        next_status = '0;
        next_status[adder_regmap_pkg::STATUS_CARRY_BIT] = next_sum[DATA_WIDTH];
        // Same operand signs, different result sign
        next_status[adder_regmap_pkg::STATUS_OVERFLOW_BIT] =
            (next_a[DATA_WIDTH-1] == next_b[DATA_WIDTH-1]) &&
            (next_sum[DATA_WIDTH-1] != next_a[DATA_WIDTH-1]);
    end

    always_ff @(posedge s1_axi_aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            operand_a <= '0;
            operand_b <= '0;
            result    <= '0;
            status    <= '0;
        end
        else if (wr_en && (wr_sel_a || wr_sel_b))
        begin
            operand_a <= next_a;
            operand_b <= next_b;
            result    <= next_sum[DATA_WIDTH-1:0];
            status    <= next_status;
        end
    end

    always_comb
    begin
        rd_data = '0;
        rd_resp = adder_axil_pkg::RESP_OKAY;
        case (rd_addr)
            ADDR_OPERAND_A: rd_data = operand_a;
            ADDR_OPERAND_B: rd_data = operand_b;
            ADDR_RESULT:    rd_data = result;
            ADDR_STATUS:    rd_data = data_t'(status);
            default:        rd_resp = adder_axil_pkg::RESP_SLVERR;
        endcase
    end

    // Commit address comes from the write controller buffer
    a_wr_addr_known: assert property (
        @(posedge s1_axi_aclk) disable iff (!arst_n)
        wr_en |-> !$isunknown(wr_addr)
    );

endmodule

// File: rtl/adder_axil_top.sv
module adder_axil_top #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 8
)
(
    input  logic                        s1_axi_aclk,
    input  logic                        arst_n,

    // Write side
    input  logic [ADDR_WIDTH-1:0]       s1_axi_awaddr,
    input  logic                        s1_axi_awvalid,
    output logic                        s1_axi_awready,
    input  logic [DATA_WIDTH-1:0]       s1_axi_wdata,
    input  logic [DATA_WIDTH/8-1:0]     s1_axi_wstrb,
    input  logic                        s1_axi_wvalid,
    output logic                        s1_axi_wready,
    output adder_axil_pkg::axil_resp_t  s1_axi_bresp,
    output logic                        s1_axi_bvalid,
    input  logic                        s1_axi_bready,

    // Read side
    input  logic [ADDR_WIDTH-1:0]       s1_axi_araddr,
    input  logic                        s1_axi_arvalid,
    output logic                        s1_axi_arready,
    output logic [DATA_WIDTH-1:0]       s1_axi_rdata,
    output adder_axil_pkg::axil_resp_t  s1_axi_rresp,
    output logic                        s1_axi_rvalid,
    input  logic                        s1_axi_rready
);

    // Write controller to register bank
    logic                        wr_en;
    logic [ADDR_WIDTH-1:0]       wr_addr;
    logic [DATA_WIDTH-1:0]       wr_data;
    logic [DATA_WIDTH/8-1:0]     wr_strb;
    adder_axil_pkg::axil_resp_t  wr_resp;

    // Read controller to register bank
    logic [ADDR_WIDTH-1:0]       rd_addr;
    logic [DATA_WIDTH-1:0]       rd_data;
    adder_axil_pkg::axil_resp_t  rd_resp;

    axil_write_ctrl #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_write_ctrl (
        .s1_axi_aclk (s1_axi_aclk),
        .arst_n      (arst_n),
        .awaddr      (s1_axi_awaddr),
        .awvalid     (s1_axi_awvalid),
        .awready     (s1_axi_awready),
        .wdata       (s1_axi_wdata),
        .wstrb       (s1_axi_wstrb),
        .wvalid      (s1_axi_wvalid),
        .wready      (s1_axi_wready),
        .bresp       (s1_axi_bresp),
        .bvalid      (s1_axi_bvalid),
        .bready      (s1_axi_bready),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_strb     (wr_strb),
        .wr_resp     (wr_resp)
    );

    axil_read_ctrl #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_read_ctrl (
        .s1_axi_aclk (s1_axi_aclk),
        .arst_n      (arst_n),
        .araddr      (s1_axi_araddr),
        .arvalid     (s1_axi_arvalid),
        .arready     (s1_axi_arready),
        .rdata       (s1_axi_rdata),
        .rresp       (s1_axi_rresp),
        .rvalid      (s1_axi_rvalid),
        .rready      (s1_axi_rready),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_resp     (rd_resp)
    );

    adder_regs #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_regs (
        .s1_axi_aclk (s1_axi_aclk),
        .arst_n      (arst_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_strb     (wr_strb),
        .wr_resp     (wr_resp),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_resp     (rd_resp)
    );

endmodule

// File: testbench/tb_adder_axil.sv
module tb_adder_axil;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 8;
    localparam int NUM_RANDOM = 100;
    localparam int RESP_LIMIT = 64;

    // About 600 bus transactions in all, each at most about 20 cycles
    localparam int NUM_TRANS      = 600;
    localparam int WORST_CYCLES   = 20;
    localparam int TIMEOUT_CYCLES = NUM_TRANS * WORST_CYCLES;

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [DATA_WIDTH/8-1:0] strb_t;
    typedef adder_axil_pkg::axil_resp_t resp_t;

    localparam addr_t ADDR_A      = addr_t'(adder_regmap_pkg::OFFSET_OPERAND_A);
    localparam addr_t ADDR_B      = addr_t'(adder_regmap_pkg::OFFSET_OPERAND_B);
    localparam addr_t ADDR_RESULT = addr_t'(adder_regmap_pkg::OFFSET_RESULT);
    localparam addr_t ADDR_STATUS = addr_t'(adder_regmap_pkg::OFFSET_STATUS);
    localparam resp_t RESP_NONE   = resp_t'(2'b11);
    localparam longint SMAX       = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
    localparam longint SMIN       = -SMAX - 1;

    logic  s1_axi_aclk;
    logic  arst_n;
    addr_t s1_axi_awaddr;
    logic  s1_axi_awvalid;
    logic  s1_axi_awready;
    data_t s1_axi_wdata;
    strb_t s1_axi_wstrb;
    logic  s1_axi_wvalid;
    logic  s1_axi_wready;
    resp_t s1_axi_bresp;
    logic  s1_axi_bvalid;
    logic  s1_axi_bready;
    addr_t s1_axi_araddr;
    logic  s1_axi_arvalid;
    logic  s1_axi_arready;
    data_t s1_axi_rdata;
    resp_t s1_axi_rresp;
    logic  s1_axi_rvalid;
    logic  s1_axi_rready;

    // Model copy of the register bank
    data_t                     model_a;
    data_t                     model_b;
    data_t                     model_result;
    adder_regmap_pkg::status_t model_status;

    logic [31:0] lfsr = 32'h11b3f4bc;
    int error_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int writes_issued = 0;
    int reads_issued = 0;
    int b_seen = 0;
    int r_seen = 0;
    int cycle_count = 0;

    adder_axil_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_adder_axil_top (
        .s1_axi_aclk    (s1_axi_aclk),
        .arst_n         (arst_n),
        .s1_axi_awaddr  (s1_axi_awaddr),
        .s1_axi_awvalid (s1_axi_awvalid),
        .s1_axi_awready (s1_axi_awready),
        .s1_axi_wdata   (s1_axi_wdata),
        .s1_axi_wstrb   (s1_axi_wstrb),
        .s1_axi_wvalid  (s1_axi_wvalid),
        .s1_axi_wready  (s1_axi_wready),
        .s1_axi_bresp   (s1_axi_bresp),
        .s1_axi_bvalid  (s1_axi_bvalid),
        .s1_axi_bready  (s1_axi_bready),
        .s1_axi_araddr  (s1_axi_araddr),
        .s1_axi_arvalid (s1_axi_arvalid),
        .s1_axi_arready (s1_axi_arready),
        .s1_axi_rdata   (s1_axi_rdata),
        .s1_axi_rresp   (s1_axi_rresp),
        .s1_axi_rvalid  (s1_axi_rvalid),
        .s1_axi_rready  (s1_axi_rready)
    );

    always #20 s1_axi_aclk = ~s1_axi_aclk;

    // Handshake counters, one count per completed B or R transfer
    always @(posedge s1_axi_aclk)
    begin
        if (s1_axi_bvalid && s1_axi_bready)
        begin
            b_seen++;
        end
        if (s1_axi_rvalid && s1_axi_rready)
        begin
            r_seen++;
        end
    end

    always @(posedge s1_axi_aclk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], next_random_bit()};
        end
        return v;
    endfunction

    // Applies one write to the model, returns the expected bresp
    function automatic resp_t ref_add(input addr_t addr, input data_t data, input strb_t strb);
        data_t              mask;
        logic [DATA_WIDTH:0] sum;
        longint             ssum;
        if (addr != ADDR_A && addr != ADDR_B)
        begin
            return adder_axil_pkg::RESP_SLVERR;
        end
        for (int i = 0; i < DATA_WIDTH/8; i++)
        begin
            mask[8*i +: 8] = {8{strb[i]}};
        end
        if (addr == ADDR_A)
        begin
            model_a = (model_a & ~mask) | (data & mask);
        end
        else
        begin
            model_b = (model_b & ~mask) | (data & mask);
        end
        sum  = model_a + model_b;
        ssum = longint'($signed(model_a)) + longint'($signed(model_b));
        model_result = sum[DATA_WIDTH-1:0];
        model_status = '0;
        model_status[adder_regmap_pkg::STATUS_CARRY_BIT]    = sum[DATA_WIDTH];
        model_status[adder_regmap_pkg::STATUS_OVERFLOW_BIT] = (ssum > SMAX) || (ssum < SMIN);
        return adder_axil_pkg::RESP_OKAY;
    endfunction

    function automatic data_t expected_read(input addr_t addr);
        if (addr == ADDR_A)
        begin
            return model_a;
        end
        if (addr == ADDR_B)
        begin
            return model_b;
        end
        if (addr == ADDR_RESULT)
        begin
            return model_result;
        end
        if (addr == ADDR_STATUS)
        begin
            return data_t'(model_status);
        end
        return '0;
    endfunction

    function automatic resp_t expected_read_resp(input addr_t addr);
        if (addr == ADDR_A || addr == ADDR_B || addr == ADDR_RESULT || addr == ADDR_STATUS)
        begin
            return adder_axil_pkg::RESP_OKAY;
        end
        return adder_axil_pkg::RESP_SLVERR;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
            error_count++;
        end
    endtask

    // AW and W run as separate threads so either may lead
    task automatic axil_write(input addr_t addr, input data_t data, input strb_t strb,
                              input int aw_d, input int w_d, input int b_d,
                              output resp_t resp);
        int   n;
        logic got;
        writes_issued++;
        resp = RESP_NONE;
        got  = 1'b0;
        fork
            begin
                repeat (aw_d) @(posedge s1_axi_aclk);
                s1_axi_awaddr  <= addr;
                s1_axi_awvalid <= 1'b1;
                do
                begin
                    @(posedge s1_axi_aclk);
                end
                while (!s1_axi_awready);
                s1_axi_awvalid <= 1'b0;
            end
            begin
                repeat (w_d) @(posedge s1_axi_aclk);
                s1_axi_wdata  <= data;
                s1_axi_wstrb  <= strb;
                s1_axi_wvalid <= 1'b1;
                do
                begin
                    @(posedge s1_axi_aclk);
                end
                while (!s1_axi_wready);
                s1_axi_wvalid <= 1'b0;
            end
        join
        if (b_d == 0)
        begin
            s1_axi_bready <= 1'b1;
        end
        n = 0;
        while (!got && n < RESP_LIMIT)
        begin
            @(posedge s1_axi_aclk);
            n++;
            if (s1_axi_bvalid && s1_axi_bready)
            begin
                got  = 1'b1;
                resp = s1_axi_bresp;
            end
            else if (n >= b_d)
            begin
                s1_axi_bready <= 1'b1;
            end
        end
        s1_axi_bready <= 1'b0;
        if (!got)
        begin
            $display("no write response for address 0x%0h after %0d cycles", addr, RESP_LIMIT);
            error_count++;
        end
    endtask

    // lat counts cycles from the AR handshake to the first rvalid
    task automatic axil_read(input addr_t addr, input int r_d, output data_t data,
                             output resp_t resp, output int lat);
        int   n;
        logic got;
        reads_issued++;
        data = '0;
        resp = RESP_NONE;
        lat  = 0;
        got  = 1'b0;
        s1_axi_araddr  <= addr;
        s1_axi_arvalid <= 1'b1;
        if (r_d == 0)
        begin
            s1_axi_rready <= 1'b1;
        end
        do
        begin
            @(posedge s1_axi_aclk);
        end
        while (!s1_axi_arready);
        s1_axi_arvalid <= 1'b0;
        n = 0;
        while (!got && n < RESP_LIMIT)
        begin
            @(posedge s1_axi_aclk);
            n++;
            if (s1_axi_rvalid && lat == 0)
            begin
                lat = n;
            end
            if (s1_axi_rvalid && s1_axi_rready)
            begin
                got  = 1'b1;
                data = s1_axi_rdata;
                resp = s1_axi_rresp;
            end
            else if (n >= r_d)
            begin
                s1_axi_rready <= 1'b1;
            end
        end
        s1_axi_rready <= 1'b0;
        if (!got)
        begin
            $display("no read response for address 0x%0h after %0d cycles", addr, RESP_LIMIT);
            error_count++;
        end
    endtask

    task automatic write_check(input string name, input addr_t addr, input data_t data,
                               input strb_t strb, input int aw_d, input int w_d, input int b_d);
        resp_t exp_resp;
        resp_t resp;
        exp_resp = ref_add(addr, data, strb);
        axil_write(addr, data, strb, aw_d, w_d, b_d, resp);
        check_value({name, " bresp"}, exp_resp, resp);
    endtask

    task automatic read_check(input string name, input addr_t addr, input int r_d,
                              output int lat);
        data_t data;
        resp_t resp;
        axil_read(addr, r_d, data, resp, lat);
        check_value({name, " rdata"}, expected_read(addr), data);
        check_value({name, " rresp"}, expected_read_resp(addr), resp);
    endtask

    task automatic end_test(input string name, input int start_errors);
        if (error_count == start_errors)
        begin
            tests_passed++;
            $display("%-16s ok", name);
        end
        else
        begin
            tests_failed++;
            $display("%-16s FAILED with %0d errors", name, error_count - start_errors);
        end
    endtask

    initial
    begin
        int    start;
        int    lat;
        addr_t addr;
        s1_axi_aclk    = 1'b0;
        arst_n         = 1'b0;
        s1_axi_awaddr  = '0;
        s1_axi_awvalid = 1'b0;
        s1_axi_wdata   = '0;
        s1_axi_wstrb   = '0;
        s1_axi_wvalid  = 1'b0;
        s1_axi_bready  = 1'b0;
        s1_axi_araddr  = '0;
        s1_axi_arvalid = 1'b0;
        s1_axi_rready  = 1'b0;
        model_a        = '0;
        model_b        = '0;
        model_result   = '0;
        model_status   = '0;
        repeat (2) @(posedge s1_axi_aclk);
        arst_n <= 1'b1;
        @(posedge s1_axi_aclk);

        start = error_count;
        check_value("reset awready", 1, s1_axi_awready);
        check_value("reset wready", 1, s1_axi_wready);
        check_value("reset arready", 1, s1_axi_arready);
        check_value("reset bvalid", 0, s1_axi_bvalid);
        check_value("reset rvalid", 0, s1_axi_rvalid);
        for (int i = 0; i < 4; i++)
        begin
            read_check("reset read", addr_t'(4 * i), 0, lat);
        end
        end_test("reset_state", start);

        // Corner pairs first, then random ones
        start = error_count;
        for (int i = 0; i < NUM_RANDOM + 2; i++)
        begin
            if (i == 0)
            begin
                write_check("add a", ADDR_A, '1, '1, 0, 0, 0);
                write_check("add b", ADDR_B, 1, '1, 0, 0, 0);
            end
            else if (i == 1)
            begin
                write_check("add a", ADDR_A, data_t'(SMAX), '1, 0, 0, 0);
                write_check("add b", ADDR_B, 1, '1, 0, 0, 0);
            end
            else
            begin
                write_check("add a", ADDR_A, rand_bits(DATA_WIDTH), '1, 0, 0, 0);
                write_check("add b", ADDR_B, rand_bits(DATA_WIDTH), '1, 0, 0, 0);
            end
            read_check("add result", ADDR_RESULT, 0, lat);
            read_check("add status", ADDR_STATUS, 0, lat);
        end
        end_test("random_add", start);

        start = error_count;
        for (int i = 0; i < 16; i++)
        begin
            addr = rand_bits(1) ? ADDR_B : ADDR_A;
            write_check("strobe write", addr, rand_bits(DATA_WIDTH), rand_bits(4), 0, 0, 0);
            read_check("strobe operand", addr, 0, lat);
            read_check("strobe result", ADDR_RESULT, 0, lat);
        end
        end_test("byte_strobes", start);

        start = error_count;
        write_check("err result", ADDR_RESULT, rand_bits(DATA_WIDTH), '1, 0, 0, 0);
        write_check("err status", ADDR_STATUS, rand_bits(DATA_WIDTH), '1, 0, 0, 0);
        write_check("err unmapped", 8'h10, rand_bits(DATA_WIDTH), '1, 0, 0, 0);
        write_check("err unaligned", 8'h02, rand_bits(DATA_WIDTH), '1, 0, 0, 0);
        for (int i = 0; i < 4; i++)
        begin
            read_check("err unchanged", addr_t'(4 * i), 0, lat);
        end
        read_check("err read unmapped", 8'h10, 0, lat);
        read_check("err read high", 8'hfc, 0, lat);
        read_check("err read unaligned", 8'h01, 0, lat);
        end_test("error_resp", start);

        // Two-bit delays give AW first, W first and both together
        start = error_count;
        for (int i = 0; i < 40; i++)
        begin
            addr = rand_bits(1) ? ADDR_B : ADDR_A;
            write_check("skew write", addr, rand_bits(DATA_WIDTH), '1,
                        rand_bits(2), rand_bits(2), rand_bits(2));
            read_check("skew result", ADDR_RESULT, rand_bits(2), lat);
        end
        // Open both response channels so any extra response gets counted
        s1_axi_bready <= 1'b1;
        s1_axi_rready <= 1'b1;
        repeat (4) @(posedge s1_axi_aclk);
        s1_axi_bready <= 1'b0;
        s1_axi_rready <= 1'b0;
        @(posedge s1_axi_aclk);
        check_value("skew b count", writes_issued, b_seen);
        check_value("skew r count", reads_issued, r_seen);
        end_test("skew_backpress", start);

        start = error_count;
        for (int i = 0; i < 8; i++)
        begin
            read_check("latency read", addr_t'(4 * (i % 4)), 0, lat);
            check_value("latency cycles", 1, lat);
        end
        end_test("read_latency", start);

        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
common/adder_axil_pkg.sv
common/adder_regmap_pkg.sv
axil/axil_write_ctrl.sv
axil/axil_read_ctrl.sv
rtl/adder_regs.sv
rtl/adder_axil_top.sv
testbench/tb_adder_axil.sv

// File: Bender.yml
package:
  name: adder_axil

sources:
  - common/adder_axil_pkg.sv
  - common/adder_regmap_pkg.sv
  - axil/axil_write_ctrl.sv
  - axil/axil_read_ctrl.sv
  - rtl/adder_regs.sv
  - rtl/adder_axil_top.sv
  - target: test
    files:
      - testbench/tb_adder_axil.sv
